/* hdl/sifh_defines.svh */
`ifndef SIFH_DEFINES_SVH
`define SIFH_DEFINES_SVH

// TDC timestamp as delivered with each hit strobe
`define SIFH_NP 8

// bin index width
// the coarse pass bins on the upper NB bits of a timestamp,
// the fine pass on the lower NB bits, so NP must be 2 * NB
`define SIFH_NB 4

// bin counter width, counts stick at all ones
`define SIFH_PEAK_MAX 8

// accepted hits that make up one histogram pass
`define SIFH_HITS_PER_PASS 64

`endif

/* hdl/sifhPkg.sv */
`default_nettype none

`include "sifh_defines.svh"

package sifhPkg;

    typedef logic [`SIFH_NP-1:0] tdcTime_t;          // raw TDC timestamp

    typedef logic [`SIFH_NB-1:0] binIdx_t;           // bin index, also the RAM address

    typedef logic [`SIFH_PEAK_MAX-1:0] binCount_t;   // saturating bin counter

    // hit counter of one pass, one bit wider to hold the full count
    typedef logic [$clog2(`SIFH_HITS_PER_PASS + 1)-1:0] hitCnt_t;

    // coarse and fine pass share these states, a pass flag tells them apart
    typedef enum logic [2:0] {
        IDLE,   // waiting for start
        CLEAR,  // zero all bins
        BUILD,  // accept hits, then drain the builder
        SCAN,   // search for the largest bin
        PEAK,   // take over the scan result
        DONE    // result valid for one cycle
    } sifhState_t;

endpackage

`default_nettype wire

/* hdl/histRam.sv */
`timescale 1ns/100ps
`default_nettype none

module histRam (
    input  wire logic               clk,
    input  wire logic               we,
    input  wire sifhPkg::binIdx_t   waddr,
    input  wire sifhPkg::binCount_t wdata,
    input  wire logic               re,
    input  wire sifhPkg::binIdx_t   raddr,
    output sifhPkg::binCount_t      rdata
);
    import sifhPkg::*;

    localparam int Depth = 2 ** $bits(binIdx_t);    // one word per bin

    binCount_t mem [Depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, returns the old word on a same-address write
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

    // three different masters share these ports through the sequencer mux
    a_waddrKnown: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    ) else $error("histRam write address unknown while we is high");

    a_raddrKnown: assert property (
        @(posedge clk) re |-> !$isunknown(raddr)
    ) else $error("histRam read address unknown while re is high");

endmodule

`default_nettype wire

/* hdl/hisBuilder.sv */
`timescale 1ns/100ps
`default_nettype none

module hisBuilder (
    input  wire logic               clk,
    input  wire logic               res,
    input  wire logic               hitIn,     // already filtered by pass
    input  wire sifhPkg::binIdx_t   bin,
    output logic                    ramRe,
    output sifhPkg::binIdx_t        ramRaddr,
    input  wire sifhPkg::binCount_t ramRdata,
    output logic                    ramWe,
    output sifhPkg::binIdx_t        ramWaddr,
    output sifhPkg::binCount_t      ramWdata
);
    import sifhPkg::*;

    logic      s1Valid;     // read data for s1Bin arrives now
    binIdx_t   s1Bin;
    logic      s2Valid;     // write stage
    binIdx_t   s2Bin;
    binCount_t s2Count;
    logic      s3Valid;     // word written on the last edge
    binIdx_t   s3Bin;
    binCount_t s3Count;
    binCount_t curCount;    // freshest count of s1Bin
    binCount_t nextCount;

    // stage one, read issued in the hit cycle
    assign ramRe    = hitIn;
    assign ramRaddr = bin;

    // The RAM word is stale in two cases: an older hit to the same bin is
    // being written right now, or it was written on the same edge that
    // captured the read. The write stage is newer, so it wins.
    always_comb begin
        if (s2Valid && (s2Bin == s1Bin)) begin
            curCount = s2Count;
        end else if (s3Valid && (s3Bin == s1Bin)) begin
            curCount = s3Count;
        end else begin
            curCount = ramRdata;
        end
    end

    assign nextCount = (curCount == '1) ? curCount : curCount + 1'b1;   // stick at 255

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= hitIn;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin   <= bin;
        s2Bin   <= s1Bin;
        s2Count <= nextCount;
        s3Bin   <= s2Bin;       // copy of the committed write
        s3Count <= s2Count;
    end

    // stage two, write back two cycles after the hit
    assign ramWe    = s2Valid;
    assign ramWaddr = s2Bin;
    assign ramWdata = s2Count;

    // every RAM word read is written back one cycle later, never smaller
    a_noDecrement: assert property (
        @(posedge clk) disable iff (!res)
        s1Valid |=> ramWe && (ramWdata >= $past(ramRdata))
    ) else $error("hisBuilder wrote back a count below the one it read");

endmodule

`default_nettype wire

/* hdl/peakFinder.sv */
`timescale 1ns/100ps
`default_nettype none

module peakFinder (
    input  wire logic               clk,
    input  wire logic               res,
    input  wire logic               scanStart,
    output logic                    ramRe,
    output sifhPkg::binIdx_t        ramRaddr,
    input  wire sifhPkg::binCount_t ramRdata,
    output logic                    scanDone,
    output sifhPkg::binIdx_t        peakBin,
    output sifhPkg::binCount_t      peakCnt
);
    import sifhPkg::*;

    localparam binIdx_t LastBin = '1;

    logic    scanning;  // read addresses being issued
    binIdx_t addr;
    logic    rdValid;   // ramRdata holds the word of rdAddr
    binIdx_t rdAddr;

    assign ramRe    = scanning;
    assign ramRaddr = addr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning <= 1'b0;
            addr     <= '0;
            rdValid  <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            rdValid  <= scanning;
            scanDone <= rdValid && (rdAddr == LastBin);   // last compare done
            if (scanStart) begin
                scanning <= 1'b1;
                addr     <= '0;
            end else if (scanning) begin
                addr <= addr + 1'b1;                       // wraps to 0 after the last bin
                if (addr == LastBin) begin
                    scanning <= 1'b0;
                end
            end
        end
    end

    // bin 0 seeds the maximum, later bins need a strictly larger count
    always_ff @(posedge clk) begin
        rdAddr <= addr;
        if (rdValid && ((rdAddr == '0) || (ramRdata > peakCnt))) begin
            peakBin <= rdAddr;
            peakCnt <= ramRdata;
        end
    end

    a_noRestart: assert property (
        @(posedge clk) disable iff (!res)
        scanStart |-> !scanning && !rdValid
    ) else $error("peakFinder got scanStart during a scan");

    // 16 reads, one cycle read latency, one for the last compare
    a_doneLatency: assert property (
        @(posedge clk) disable iff (!res)
        scanStart |-> ##18 scanDone
    ) else $error("peakFinder scanDone not 18 cycles after scanStart");

endmodule

`default_nettype wire

/* hdl/sifhTop.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sifh_defines.svh"

module sifhTop (
    input  wire logic              clk,
    input  wire logic              res,
    input  wire logic              start,
    input  wire logic              hit,
    input  wire sifhPkg::tdcTime_t data,
    output logic                   wrEn,
    output logic                   busy,
    output logic                   peakValid,
    output sifhPkg::tdcTime_t      peakTime,
    output sifhPkg::binCount_t     peakCount
);
    import sifhPkg::*;

    localparam hitCnt_t HitsPerPass = hitCnt_t'(`SIFH_HITS_PER_PASS);
    localparam binIdx_t LastBin     = '1;

    sifhState_t state;
    logic       finePass;       // second pass, window active
    binIdx_t    clrAddr;
    hitCnt_t    hitCnt;         // accepted hits of this pass
    logic       drainCnt;       // builder drain cycle
    logic       scanStart;
    binIdx_t    coarsePeak;     // window of the fine pass

    binIdx_t    coarseBin;
    binIdx_t    fineBin;
    binIdx_t    hitBin;
    logic       accept;
    logic       winHit;

    logic       ramWe;
    binIdx_t    ramWaddr;
    binCount_t  ramWdata;
    logic       ramRe;
    binIdx_t    ramRaddr;
    binCount_t  ramRdata;

    logic       hbRe;
    binIdx_t    hbRaddr;
    logic       hbWe;
    binIdx_t    hbWaddr;
    binCount_t  hbWdata;

    logic       pfRe;
    binIdx_t    pfRaddr;
    logic       scanDone;
    binIdx_t    peakBin;
    binCount_t  peakCnt;

    assign coarseBin = data[`SIFH_NP-1 -: `SIFH_NB];
    assign fineBin   = data[`SIFH_NB-1:0];
    assign hitBin    = finePass ? fineBin : coarseBin;

    assign wrEn      = (state == BUILD) && (hitCnt != HitsPerPass);
    assign accept    = hit && wrEn;                                        // counts toward the pass
    assign winHit    = accept && (!finePass || (coarseBin == coarsePeak)); // goes into the histogram
    assign busy      = (state != IDLE) && (state != DONE);
    assign peakValid = (state == DONE);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= IDLE;
            finePass  <= 1'b0;
            clrAddr   <= '0;
            hitCnt    <= '0;
            drainCnt  <= 1'b0;
            scanStart <= 1'b0;
        end else begin
            scanStart <= 1'b0;
            case (state)
                IDLE, DONE: begin
                    state <= IDLE;
                    if (start) begin     // DONE already counts as not busy
                        state    <= CLEAR;
                        finePass <= 1'b0;
                        clrAddr  <= '0;
                    end
                end
                CLEAR: begin
                    clrAddr <= clrAddr + 1'b1;
                    if (clrAddr == LastBin) begin
                        state    <= BUILD;
                        hitCnt   <= '0;
                        drainCnt <= 1'b0;
                    end
                end
                BUILD: begin
                    if (accept) begin
                        hitCnt <= hitCnt + 1'b1;
                    end
                    if (hitCnt == HitsPerPass) begin   // last write lands 2 cycles later
                        drainCnt <= 1'b1;
                        if (drainCnt) begin
                            state     <= SCAN;
                            scanStart <= 1'b1;
                        end
                    end
                end
                SCAN: begin
                    if (scanDone) begin
                        state <= PEAK;
                    end
                end
                PEAK: begin
                    if (finePass) begin
                        state <= DONE;
                    end else begin
                        state    <= CLEAR;    // second clear for the fine pass
                        finePass <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // result registers change on the same edge that raises peakValid
    always_ff @(posedge clk) begin
        if (state == PEAK) begin
            if (finePass) begin
                peakTime  <= {coarsePeak, peakBin};
                peakCount <= peakCnt;
            end else begin
                coarsePeak <= peakBin;
            end
        end
    end

    always_comb begin
        ramWe    = 1'b0;
        ramWaddr = clrAddr;
        ramWdata = '0;
        ramRe    = 1'b0;
        ramRaddr = pfRaddr;
        case (state)
            CLEAR: ramWe = 1'b1;   // zero one bin per cycle
            BUILD: begin
                ramWe    = hbWe;
                ramWaddr = hbWaddr;
                ramWdata = hbWdata;
                ramRe    = hbRe;
                ramRaddr = hbRaddr;
            end
            SCAN: ramRe = pfRe;
            default: ;
        endcase
    end

    histRam ram0 (
        .clk   (clk),
        .we    (ramWe),
        .waddr (ramWaddr),
        .wdata (ramWdata),
        .re    (ramRe),
        .raddr (ramRaddr),
        .rdata (ramRdata)
    );

    hisBuilder builder0 (
        .clk      (clk),
        .res      (res),
        .hitIn    (winHit),
        .bin      (hitBin),
        .ramRe    (hbRe),
        .ramRaddr (hbRaddr),
        .ramRdata (ramRdata),
        .ramWe    (hbWe),
        .ramWaddr (hbWaddr),
        .ramWdata (hbWdata)
    );

    peakFinder finder0 (
        .clk       (clk),
        .res       (res),
        .scanStart (scanStart),
        .ramRe     (pfRe),
        .ramRaddr  (pfRaddr),
        .ramRdata  (ramRdata),
        .scanDone  (scanDone),
        .peakBin   (peakBin),
        .peakCnt   (peakCnt)
    );

    // hits are only taken while the scanner leaves the RAM alone
    a_wrEnInBuild: assert property (
        @(posedge clk) disable iff (!res)
        wrEn |-> (state == BUILD) && !pfRe && ($rose(wrEn) -> ($past(state) == CLEAR))
    ) else $error("wrEn high outside BUILD, during a scan or without a preceding clear");

    // the builder must be empty before the scan reads the RAM
    a_drainedForScan: assert property (
        @(posedge clk) disable iff (!res)
        (state == SCAN) |-> !hbWe
    ) else $error("histogram write still pending during SCAN");

endmodule

`default_nettype wire

/* bench/sifhBench.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sifh_defines.svh"

module sifhBench;
    import sifhPkg::*;

    // worst case per measurement is two passes at 4 cycles per hit, plus overhead
    localparam int CyclesPerMeas = 2 * `SIFH_HITS_PER_PASS * 4 + 100;

    logic      clk;
    logic      res;
    logic      start;
    logic      hit;
    tdcTime_t  data;
    logic      wrEn;
    logic      busy;
    logic      peakValid;
    tdcTime_t  peakTime;
    binCount_t peakCount;

    tdcTime_t  hitQ[$];         // all timestamps in file order
    int        blockEnd[$];     // hitQ index just past each block
    tdcTime_t  expTime[$];
    binCount_t expCount[$];
    int        errors = 0;
    int        checks = 0;
    int        validCnt = 0;    // peakValid pulses seen
    bit        loaded = 1'b0;

    sifhTop dut0 (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .hit       (hit),
        .data      (data),
        .wrEn      (wrEn),
        .busy      (busy),
        .peakValid (peakValid),
        .peakTime  (peakTime),
        .peakCount (peakCount)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(negedge clk) begin
        if (res && peakValid) begin
            validCnt++;
        end
    end

    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #5;                     // inputs change well clear of the edge
    endtask

    // H lines add hits, an E line closes a measurement with its result
    task automatic loadGolden();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("bench/sifhGolden.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/sifhGolden.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %h %h", tag, a, b);
                if (n != 3) begin
                    $display("malformed line in golden file: %s", line);
                    errors++;
                end else if (tag == "H") begin
                    repeat (b) hitQ.push_back(a[7:0]);
                end else if (tag == "E") begin
                    blockEnd.push_back(hitQ.size());
                    expTime.push_back(a[7:0]);
                    expCount.push_back(b[7:0]);
                end else begin
                    $display("unknown record type in golden file: %s", line);
                    errors++;
                end
            end
        end
        $fclose(fd);
        if (expTime.size() == 0) begin
            $display("golden file holds no measurement");
            errors++;
        end
    endtask

    task automatic runMeasurement(input int m, inout int idx);
        int gap;
        bit got;
        start = 1'b1;
        nextCycle();
        checkVal("busy", 32'(busy), 32'd1);
        gap = 0;
        got = 1'b0;
        while (!got) begin
            start = 1'b0;
            hit   = 1'b0;
            if (peakValid) begin
                checkVal("peakTime", 32'(peakTime), 32'(expTime[m]));
                checkVal("peakCount", 32'(peakCount), 32'(expCount[m]));
                checkVal("busy", 32'(busy), 32'd0);
                checkVal("hitsUsed", 32'(idx), 32'(blockEnd[m]));
                got = 1'b1;
            end else if (wrEn) begin
                if (gap > 0) begin
                    gap--;
                end else if (idx < blockEnd[m]) begin
                    hit  = 1'b1;
                    data = hitQ[idx];
                    idx++;
                    gap  = int'($urandom % 4);
                end
            end else begin
                // strobes and starts here must all be dropped
                hit   = ($urandom % 2) == 1;
                data  = tdcTime_t'($urandom);
                start = busy && (($urandom % 8) == 0);
            end
            if (!got) begin
                nextCycle();
            end
        end
    endtask

    initial begin
        int idx;
        int m;
        res   = 1'b0;
        start = 1'b0;
        hit   = 1'b0;
        data  = '0;
        void'($urandom(32'h2e12));
        loadGolden();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        #5;
        res = 1'b1;
        checkVal("wrEn", 32'(wrEn), 32'd0);
        checkVal("busy", 32'(busy), 32'd0);
        checkVal("peakValid", 32'(peakValid), 32'd0);
        repeat (8) begin        // idle strobes without a start
            hit  = ($urandom % 2) == 1;
            data = tdcTime_t'($urandom);
            nextCycle();
        end
        hit = 1'b0;
        checkVal("peakValidCount", 32'(validCnt), 32'd0);
        idx = 0;
        for (m = 0; m < expTime.size(); m++) begin
            runMeasurement(m, idx);
        end
        nextCycle();
        nextCycle();
        checkVal("peakValidCount", 32'(validCnt), 32'(expTime.size()));
        $display("%0d measurements, %0d checks, %0d errors", expTime.size(), checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat (expTime.size() * CyclesPerMeas + 50) @(posedge clk);
        $display("timeout, the core did not deliver all results in time");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sifhTop.f */
+incdir+hdl
hdl/sifhPkg.sv
hdl/histRam.sv
hdl/hisBuilder.sv
hdl/peakFinder.sv
hdl/sifhTop.sv
bench/sifhBench.sv

/* Makefile */
# Verilator build and run of the sifhTop testbench

SIM := obj_dir/sifhSim
LOG := sim.log

.PHONY: all run lint clean

all: run

$(SIM): sifhTop.f hdl/*.sv hdl/*.svh bench/sifhBench.sv
	verilator --binary --timing --assert -sv -f sifhTop.f --top-module sifhBench -o sifhSim

# pass or fail is taken from the log, not from the simulator exit code
run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	verilator --lint-only --timing -Wall -sv -f sifhTop.f --top-module sifhTop

clean:
	rm -rf obj_dir $(LOG)

/* bench/sifhGolden.txt */
# H <timestamp hex> <repeat count hex> adds hits, 64 coarse then 64 fine per measurement
# E <peakTime hex> <peakCount hex> closes a measurement with its expected result
# single dominant timestamp
H 5a 40
H 5a 40
E 5a 40
# heavy off-window traffic in the fine pass
H 37 14
H 81 10
H c4 1c
H 2f 14
H c9 0c
H 77 12
H c3 0a
H e9 04
E c9 0c
# coarse tie between bins 9 and 4, fine tie between bins 7 and 2
H 9b 20
H 4e 20
H 47 10
H 42 10
H 4f 08
H 55 18
E 42 10
# back-to-back hits alternating between bins
H 63 03
H a0 01
H 63 01
H a0 02
H 6c 01
H 63 01
H a0 01
H 6c 32
H a0 04
H 63 01
H 6c 01
H 63 01
H 6c 01
H 63 02
H 6c 02
H 0c 01
H 6c 01
H 63 01
H 6c 03
H 63 2f
H f3 03
E 63 34
# top coarse bin, fine tie between bins 1 and e
H f0 21
H 00 1f
H 0f 3c
H f1 02
H fe 02
E f1 02
# no fine hit inside the window
H 2a 40
H 33 40
E 20 00
